/* hdl/mod53_cfg.svh */
`ifndef MOD53_CFG_SVH
`define MOD53_CFG_SVH

// Operand width, split into two equal halves
`define MOD53_OPERAND_BITS 96

// Bits consumed per fold step
`define MOD53_CHUNK_BITS 6

`define MOD53_MODULUS 53

// 2^6 mod 53, so 64 folds to 11
`define MOD53_CHUNK_FOLD 11

`endif

/* hdl/mod53_pkg.sv */
`default_nettype none

`include "mod53_cfg.svh"

package mod53_pkg;

	// Residue 0..52 always fits in one chunk width
	typedef logic [`MOD53_CHUNK_BITS-1:0] residue_t;

	// One half of the operand, handled by one folder
	typedef logic [`MOD53_OPERAND_BITS/2-1:0] half_t;

	typedef struct packed {
		half_t hi; // Upper bits, weighted by 2^48 later
		half_t lo;
	} operand_halves_t;

	// Same operand word, flat on the port and split for the folders
	typedef union packed {
		logic [`MOD53_OPERAND_BITS-1:0] flat;
		operand_halves_t                halves;
	} operand_u;

	// Both partial residues, handed to the combiner together
	typedef struct packed {
		residue_t r_hi;
		residue_t r_lo;
	} partial_pair_t;

endpackage

`default_nettype wire

/* hdl/chunk_folder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mod53_cfg.svh"

module chunk_folder
(
	input  logic                clk,
	input  logic                rst,
	input  logic                start,
	input  mod53_pkg::half_t    half,
	output mod53_pkg::residue_t residue,
	output logic                done
);

	localparam int HALF_BITS  = $bits(mod53_pkg::half_t);
	localparam int CHUNK_BITS = `MOD53_CHUNK_BITS;
	localparam int CHUNKS     = HALF_BITS / CHUNK_BITS;
	localparam int CNT_BITS   = $clog2(CHUNKS + 1);
	localparam int STEP_BITS  = 10; // 52*11 + 63 stays below 1024
	localparam int FOLD_BITS  = 8;  // 63 + 9*11 stays below 256
	localparam int FOLD       = `MOD53_CHUNK_FOLD;
	localparam int MODULUS    = `MOD53_MODULUS;

	mod53_pkg::half_t      shreg;
	mod53_pkg::residue_t   acc;
	mod53_pkg::residue_t   acc_in;
	mod53_pkg::residue_t   acc_next;
	logic [CHUNK_BITS-1:0] chunk;
	logic [CNT_BITS-1:0]   steps_left;
	logic                  step;

	// One Horner step: acc*64 + chunk, with 64 replaced by 11
	function automatic mod53_pkg::residue_t fold_step
	(
		input mod53_pkg::residue_t   a,
		input logic [CHUNK_BITS-1:0] c
	);
		logic [STEP_BITS-1:0] t;
		logic [FOLD_BITS-1:0] f;
		t = STEP_BITS'(a) * STEP_BITS'(FOLD) + STEP_BITS'(c);
		// Bits above six are worth 64 each, fold them back as 11
		f = FOLD_BITS'(t[CHUNK_BITS-1:0]) +
			FOLD_BITS'(t[STEP_BITS-1:CHUNK_BITS]) * FOLD_BITS'(FOLD);
		for (int i = 0; i < 3; i++)
		begin
			if (f >= FOLD_BITS'(MODULUS))
				f = f - FOLD_BITS'(MODULUS);
		end
		return f[CHUNK_BITS-1:0];
	endfunction

	// The start cycle already consumes the top chunk of the new half
	assign step     = start || (steps_left != '0);
	assign chunk    = start ? half[HALF_BITS-1 -: CHUNK_BITS] : shreg[HALF_BITS-1 -: CHUNK_BITS];
	assign acc_in   = start ? '0 : acc;
	assign acc_next = fold_step(acc_in, chunk);

	always_ff @(posedge clk)
	begin
		if (step)
		begin
			acc   <= acc_next;
			shreg <= (start ? half : shreg) << CHUNK_BITS; // Next chunk moves to the top
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			steps_left <= '0;
			done       <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			if (start)
				steps_left <= CNT_BITS'(CHUNKS - 1); // First chunk taken at start
			else if (steps_left != '0)
			begin
				steps_left <= steps_left - 1'b1;
				done       <= (steps_left == CNT_BITS'(1)); // Last chunk folded
			end
		end
	end

	assign residue = acc;

endmodule

`default_nettype wire

/* hdl/residue_combiner.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mod53_cfg.svh"

module residue_combiner
(
	input  logic                     clk,
	input  logic                     rst,
	input  mod53_pkg::partial_pair_t pair,
	input  logic                     pair_valid,
	output mod53_pkg::residue_t      sum,
	output logic                     sum_valid
);

	localparam int HALF_BITS  = `MOD53_OPERAND_BITS / 2;
	localparam int CHUNK_BITS = `MOD53_CHUNK_BITS;
	localparam int FOLD       = `MOD53_CHUNK_FOLD;
	localparam int MODULUS    = `MOD53_MODULUS;
	localparam int WIDE_BITS  = 12; // Any weight below 53 keeps r_hi*w + r_lo under 4096

	// 2^HALF_BITS mod 53, built one chunk at a time from 64 = 11
	function automatic int half_weight();
		int w;
		w = 1;
		for (int i = 0; i < HALF_BITS / CHUNK_BITS; i++)
			w = (w * FOLD) % MODULUS;
		return w;
	endfunction

	localparam logic [CHUNK_BITS-1:0] HALF_WEIGHT = CHUNK_BITS'(half_weight());

	// Upper bits count 64 each, which is 11 mod 53
	function automatic logic [WIDE_BITS-1:0] fold64(input logic [WIDE_BITS-1:0] x);
		return WIDE_BITS'(x[CHUNK_BITS-1:0]) +
			WIDE_BITS'(x[WIDE_BITS-1:CHUNK_BITS]) * WIDE_BITS'(FOLD);
	endfunction

	logic [WIDE_BITS-1:0] weighted;
	logic [WIDE_BITS-1:0] fold_a;
	logic [WIDE_BITS-1:0] fold_b;
	logic [WIDE_BITS-1:0] fold_c;
	mod53_pkg::residue_t  reduced;

	assign weighted = WIDE_BITS'(pair.r_hi) * WIDE_BITS'(HALF_WEIGHT) + WIDE_BITS'(pair.r_lo);

	// Bounds shrink 4095 -> 756 -> 184 -> 85
	assign fold_a = fold64(weighted);
	assign fold_b = fold64(fold_a);
	assign fold_c = fold64(fold_b);

	// One subtraction brings 85 down into 0..52
	always_comb
	begin
		if (fold_c >= WIDE_BITS'(MODULUS))
			reduced = CHUNK_BITS'(fold_c - WIDE_BITS'(MODULUS));
		else
			reduced = fold_c[CHUNK_BITS-1:0];
	end

	always_ff @(posedge clk)
	begin
		if (pair_valid)
			sum <= reduced;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			sum_valid <= 1'b0;
		else
			sum_valid <= pair_valid;
	end

endmodule

`default_nettype wire

/* hdl/mod53_reducer.sv */
`timescale 1ns/1ps
`default_nettype none

module mod53_reducer
(
	input  logic                clk,
	input  logic                rst,
	input  logic                req,
	input  mod53_pkg::operand_u operand,
	output logic                ack,
	output mod53_pkg::residue_t result
);

	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_BUSY = 2'd1; // Folders and combiner working
	localparam logic [1:0] ST_HOLD = 2'd2; // ack high, waiting for req to drop

	logic [1:0]               state;
	logic [1:0]               state_next;
	logic                     accept;
	logic                     start;
	mod53_pkg::operand_u      op_q;
	mod53_pkg::residue_t      res_hi;
	mod53_pkg::residue_t      res_lo;
	logic                     done_hi;
	logic                     done_lo;
	mod53_pkg::partial_pair_t pair;
	logic                     pair_valid;
	mod53_pkg::residue_t      sum;
	logic                     sum_valid;

	// New request only from idle with the previous ack gone
	assign accept = (state == ST_IDLE) && req && !ack;

	always_comb
	begin
		state_next = state;
		case (state)
			ST_IDLE:
				if (accept)
					state_next = ST_BUSY;
			ST_BUSY:
				if (sum_valid)
					state_next = ST_HOLD;
			ST_HOLD:
				if (!req)
					state_next = ST_IDLE;
			default:
				state_next = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state  <= ST_IDLE;
			start  <= 1'b0;
			ack    <= 1'b0;
			result <= '0;
		end
		else
		begin
			state <= state_next;
			start <= accept; // Single-cycle pulse to both folders
			if ((state == ST_BUSY) && sum_valid)
			begin
				ack    <= 1'b1;
				result <= sum; // Held until the next accepted request
			end
			else if ((state == ST_HOLD) && !req)
				ack <= 1'b0;
		end
	end

	// Operand copy keeps the halves steady through the fold
	always_ff @(posedge clk)
	begin
		if (accept)
			op_q <= operand;
	end

	chunk_folder fold_hi
	(
		.clk     (clk),
		.rst     (rst),
		.start   (start),
		.half    (op_q.halves.hi),
		.residue (res_hi),
		.done    (done_hi)
	);

	chunk_folder fold_lo
	(
		.clk     (clk),
		.rst     (rst),
		.start   (start),
		.half    (op_q.halves.lo),
		.residue (res_lo),
		.done    (done_lo)
	);

	// Both folders run the same step count, so the done pulses line up
	assign pair       = '{r_hi: res_hi, r_lo: res_lo};
	assign pair_valid = done_hi && done_lo;

	residue_combiner combiner
	(
		.clk        (clk),
		.rst        (rst),
		.pair       (pair),
		.pair_valid (pair_valid),
		.sum        (sum),
		.sum_valid  (sum_valid)
	);

endmodule

`default_nettype wire

/* verif/mod53_reducer_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module mod53_reducer_sva
(
	input logic                clk,
	input logic                rst,
	input logic                req,
	input logic                ack,
	input logic                accept,
	input mod53_pkg::residue_t result
);

	logic [9:0] accept_hist; // Captures seen on the last ten edges

	always_ff @(posedge clk)
	begin
		if (rst)
			accept_hist <= '0;
		else
			accept_hist <= {accept_hist[8:0], accept};
	end

	ack_needs_req: assert property (@(posedge clk) disable iff (rst)
		$rose(ack) |-> $past(req))
		else $error("ack rose while req was low");

	result_held: assert property (@(posedge clk) disable iff (rst)
		(ack && $past(ack)) |-> $stable(result))
		else $error("result changed while ack was high");

	ack_follows_req: assert property (@(posedge clk) disable iff (rst)
		$fell(req) |-> ##2 !ack)
		else $error("ack still high two edges after req fell");

	ack_not_early: assert property (@(posedge clk) disable iff (rst)
		$rose(ack) |-> (accept_hist == '0))
		else $error("ack rose within ten edges of a capture");

endmodule

bind mod53_reducer mod53_reducer_sva sva_inst
(
	.clk    (clk),
	.rst    (rst),
	.req    (req),
	.ack    (ack),
	.accept (accept),
	.result (result)
);

`default_nettype wire

/* verif/mod53_reducer_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mod53_cfg.svh"

module mod53_reducer_tb;

	localparam int OP_BITS      = `MOD53_OPERAND_BITS;
	localparam int LATENCY      = 10; // Edges from capture to ack
	localparam int ACK_LIMIT    = 20;
	localparam int CLK_PERIOD   = 40;
	localparam int NUM_DIRECTED = 8;
	localparam int NUM_RANDOM   = 200;
	localparam int NUM_B2B      = 20;
	localparam int NUM_TXN      = NUM_DIRECTED + NUM_RANDOM + NUM_B2B;

	logic                clk;
	logic                rst;
	logic                req;
	logic                ack;
	mod53_pkg::operand_u operand;
	mod53_pkg::residue_t result;

	logic [OP_BITS-1:0] op_q[$]; // Operands in flight with the oldest first
	string              name_q[$];
	int                 test_cnt;
	int                 pass_cnt;
	int                 fail_cnt;
	int                 error_cnt;

	mod53_reducer mod53_reducer_inst
	(
		.clk     (clk),
		.rst     (rst),
		.req     (req),
		.operand (operand),
		.ack     (ack),
		.result  (result)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// Plain remainder of the whole operand
	function automatic mod53_pkg::residue_t ref_mod53(input logic [OP_BITS-1:0] value);
		logic [OP_BITS-1:0] rem;
		rem = value % OP_BITS'(`MOD53_MODULUS);
		return rem[`MOD53_CHUNK_BITS-1:0];
	endfunction

	// Full four-phase cycle entered and left 2 ns after a rising edge
	task automatic send(input logic [OP_BITS-1:0] value, input string name, input int hold_edges);
		int waited;
		operand.flat = value;
		req          = 1'b1;
		op_q.push_back(value);
		name_q.push_back(name);
		waited = 0;
		while (!ack && waited < ACK_LIMIT)
		begin
			@(posedge clk);
			#2;
			waited++;
		end
		if (!ack)
		begin
			$display("ack never rose for %s", name);
			error_cnt++;
		end
		// Keep req up a while so ack and result must stay put
		repeat (hold_edges)
		begin
			@(posedge clk);
			#2;
		end
		req    = 1'b0;
		waited = 0;
		while (ack && waited < ACK_LIMIT)
		begin
			@(posedge clk);
			#2;
			waited++;
		end
		if (ack)
		begin
			$display("ack stayed high after req dropped for %s", name);
			error_cnt++;
		end
	endtask

	initial
	begin
		void'($urandom(85));
		clk          = 1'b0;
		rst          = 1'b1;
		req          = 1'b0;
		operand.flat = '0;
		test_cnt     = 0;
		pass_cnt     = 0;
		fail_cnt     = 0;
		error_cnt    = 0;
		repeat (3) @(posedge clk);
		#2;
		rst = 1'b0;
		if (ack !== 1'b0 || result !== '0)
		begin
			$display("Error %0t ns: ack or result not cleared by reset", $time);
			error_cnt++;
		end

		send('0, "zero", 0);
		send(OP_BITS'(52), "52", 0);
		send(OP_BITS'(53), "53", 0);
		send(OP_BITS'(54), "54", 0);
		send(OP_BITS'(53) * 96'h0023_4567_89ab_cdef_0123_4567, "multiple of 53", 0);
		send('1, "all ones", 0);
		send({48'hdead_beef_cafe, 48'h0}, "high half only", 0);
		send({48'h0, 48'h1357_9bdf_2468}, "low half only", 0);

		for (int i = 0; i < NUM_RANDOM; i++)
			send({$urandom, $urandom, $urandom}, $sformatf("random %0d", i), i % 3);

		// Large and small in turn so a stale residue would show
		for (int i = 0; i < NUM_B2B; i++)
		begin
			if (i % 2 == 0)
				send({$urandom | 32'h8000_0000, $urandom, $urandom},
					$sformatf("large %0d", i), 0);
			else
				send(OP_BITS'($urandom_range(0, 300)), $sformatf("small %0d", i), 0);
		end

		repeat (3) @(posedge clk);
		if (op_q.size() != 0)
		begin
			$display("%0d results never arrived", op_q.size());
			error_cnt++;
		end
		$display("Tests: %0d, passed: %0d, failed: %0d, other errors: %0d",
			test_cnt, pass_cnt, fail_cnt, error_cnt);
		if (fail_cnt == 0 && error_cnt == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

	// Compare process sampling 1 ns after each edge while inputs are steady
	initial
	begin
		logic                ack_prev;
		logic                busy;
		logic                test_ok;
		int                  edge_cnt;
		logic [OP_BITS-1:0]  op_value;
		string               name;
		mod53_pkg::residue_t expected;
		ack_prev = 1'b0;
		busy     = 1'b0;
		edge_cnt = 0;
		forever
		begin
			@(posedge clk);
			#1;
			if (rst)
				busy = 1'b0;
			else if (busy)
			begin
				edge_cnt++;
				if (ack)
				begin
					busy = 1'b0;
					if (op_q.size() == 0)
					begin
						$display("ack rose with no request outstanding");
						error_cnt++;
					end
					else
					begin
						op_value = op_q.pop_front();
						name     = name_q.pop_front();
						expected = ref_mod53(op_value);
						test_ok  = 1'b1;
						test_cnt++;
						if (result !== expected)
						begin
							$display("Error %0t ns: %s gave %0d, expected %0d",
								$time, name, result, expected);
							test_ok = 1'b0;
						end
						if (edge_cnt != LATENCY)
						begin
							$display("Error %0t ns: %s acked after %0d edges, expected %0d",
								$time, name, edge_cnt, LATENCY);
							test_ok = 1'b0;
						end
						if (!req)
						begin
							$display("ack rose after req had already dropped for %s", name);
							test_ok = 1'b0;
						end
						if (test_ok)
							pass_cnt++;
						else
							fail_cnt++;
						$display("Test %0d %s: %s", test_cnt, name, test_ok ? "pass" : "fail");
					end
				end
			end
			else if (req && !ack_prev)
			begin
				busy     = 1'b1; // This edge is the capture edge
				edge_cnt = 0;
			end
			else if (ack && !ack_prev)
			begin
				$display("ack rose without a request");
				error_cnt++;
			end
			if (ack_prev && !ack && req)
			begin
				$display("ack dropped while req was still high");
				error_cnt++;
			end
			ack_prev = ack;
		end
	end

	initial
	begin
		#(NUM_TXN * 14 * CLK_PERIOD + 50 * CLK_PERIOD);
		$display("Watchdog expired before all transactions finished");
		$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire

/* project.f */
+incdir+hdl
hdl/mod53_pkg.sv
hdl/chunk_folder.sv
hdl/residue_combiner.sv
hdl/mod53_reducer.sv
verif/mod53_reducer_sva.sv
verif/mod53_reducer_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = mod53_reducer_tb
FILELIST  = project.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Done: no errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
